/* src.f */
design/mm_pkg.sv
design/mm_apb_regs.sv
design/mm_row_buffer.sv
design/mm_dma_engine.sv
design/mm_engine.sv
design/mm_accel_top.sv
testbench/mm_accel_sva.sv
testbench/mm_accel_tb.sv

/* testbench/mm_accel_tb.sv */
// testbench for the matrix-multiply accelerator
// APB driver, memory model with random stalls, reference matrix model
`timescale 1ns/10ps

module mm_accel_tb;
    import mm_pkg::*;

    localparam int NUM_JOBS   = 5;
    localparam int JOB_CYCLES = 400;
    localparam int REG_CYCLES = 300;

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    mem_req_t  mem_req;
    logic      mem_ready;
    mem_rsp_t  mem_rsp;

    // sparse memory, read queue with due cycles
    word_t       mem [word_t];
    word_t       rd_data_q [$];
    int unsigned rd_due_q [$];
    int unsigned cyc;
    int          write_count;
    word_t       cur_c;

    mm_accel_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .apb_i           (apb_req),
        .apb_o           (apb_rsp),
        .mem_req_o       (mem_req),
        .mem_req_ready_i (mem_ready),
        .mem_rsp_i       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(status_t got, status_t exp, string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s busy/done %b/%b expected %b/%b",
                     $time, what, got.busy, got.done, exp.busy, exp.done);
            abort_run();
        end
    endtask

    task automatic check_slverr(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s pslverr %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // memory side, requests sampled on the edge that accepts them
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            mem_rsp   <= '0;
        end else begin
            cyc = cyc + 1;
            if (mem_req.valid && mem_ready) begin
                if (mem_req.write) begin
                    store_c_word(mem_req.addr, mem_req.wdata);
                end else begin
                    if (!mem.exists(mem_req.addr)) begin
                        $display("DMA read an address that holds no matrix row");
                        abort_run();
                    end
                    rd_data_q.push_back(mem[mem_req.addr]);
                    rd_due_q.push_back(cyc + $urandom_range(1, 6));
                end
            end
            // in-order responses, head waits for its due cycle
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
                mem_rsp <= '{valid: 1'b1, rdata: rd_data_q.pop_front()};
                void'(rd_due_q.pop_front());
            end else begin
                mem_rsp <= '0;
            end
            mem_ready <= ($urandom_range(0, 3) != 0);
        end
    end

    task automatic store_c_word(word_t addr, word_t data);
        if (addr < cur_c || addr >= cur_c + 32'd64 || addr[1:0] != 2'b00) begin
            $display("error at %0t ns: write to unexpected address %h", $time, addr);
            abort_run();
        end
        mem[addr]   = data;
        write_count = write_count + 1;
    endtask

    // one zero-wait APB transfer, response sampled mid access phase
    task automatic apb_access(input logic wr, input logic [7:0] addr, input word_t wdata,
                              output word_t rdata, output logic slverr);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        // zero-wait slave completes every access phase
        if (apb_rsp.pready !== 1'b1) begin
            $display("error at %0t ns: pready %b in the access phase", $time,
                     apb_rsp.pready);
            abort_run();
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic reg_write(logic [7:0] addr, word_t data);
        word_t rd;
        logic  err;
        apb_access(1'b1, addr, data, rd, err);
        check_slverr(err, 1'b0, "mapped write");
    endtask

    task automatic reg_read(input logic [7:0] addr, output word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_slverr(err, 1'b0, "mapped read");
    endtask

    task automatic read_status(output status_t st);
        word_t d;
        reg_read(REG_CTRL, d);
        // ctrl holds busy in bit 0, done in bit 1
        st.busy = d[0];
        st.done = d[1];
    endtask

    task automatic check_bases(word_t a, word_t b, word_t c, string what);
        word_t d;
        reg_read(REG_A_ADDR, d);
        check_word(d, a, {what, " A base"});
        reg_read(REG_B_ADDR, d);
        check_word(d, b, {what, " B base"});
        reg_read(REG_C_ADDR, d);
        check_word(d, c, {what, " C base"});
    endtask

    task automatic register_tests();
        word_t      a;
        word_t      b;
        word_t      c;
        word_t      d;
        logic       err;
        logic [7:0] off;
        for (int n = 0; n < 4; n++) begin
            a = $urandom & 32'hFFFF_FFFC;
            b = $urandom & 32'hFFFF_FFFC;
            c = $urandom & 32'hFFFF_FFFC;
            reg_write(REG_A_ADDR, a);
            reg_write(REG_B_ADDR, b);
            reg_write(REG_C_ADDR, c);
            check_bases(a, b, c, "read-back");
            off = 8'h00;
            while (off == 8'h00 || off == 8'h04 || off == 8'h08 || off == 8'h0C) begin
                off = 8'($urandom_range(0, 255));
            end
            apb_access(1'b1, off, $urandom, d, err);
            check_slverr(err, 1'b1, "unmapped write");
            apb_access(1'b0, off, '0, d, err);
            check_slverr(err, 1'b1, "unmapped read");
            check_word(d, '0, "unmapped read data");
            check_bases(a, b, c, "after unmapped access");
        end
    endtask

    // separate 1 MB regions keep A, B and C apart
    function automatic word_t rand_base(int region);
        return (word_t'(region) << 20) | word_t'($urandom_range(0, 1023) << 4);
    endfunction

    task automatic run_job(bit busy_checks);
        word_t   a;
        word_t   b;
        word_t   row;
        status_t st;
        int      am [4][4];
        int      bm [4][4];
        int      cv;
        a     = rand_base(1);
        b     = rand_base(2);
        cur_c = rand_base(3);
        // random signed matrices, one row per word
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                am[r][k] = int'(elem_t'($urandom_range(0, 255)));
                bm[r][k] = int'(elem_t'($urandom_range(0, 255)));
            end
            for (int k = 0; k < 4; k++) begin
                row[8*k +: 8] = am[r][k][7:0];
            end
            mem[a + 4*r] = row;
            for (int k = 0; k < 4; k++) begin
                row[8*k +: 8] = bm[r][k][7:0];
            end
            mem[b + 4*r] = row;
        end
        for (int n = 0; n < 16; n++) begin
            mem.delete(cur_c + 4*n);
        end
        write_count = 0;
        reg_write(REG_A_ADDR, a);
        reg_write(REG_B_ADDR, b);
        reg_write(REG_C_ADDR, cur_c);
        reg_write(REG_CTRL, 32'd1);
        read_status(st);
        check_status(st, '{busy: 1'b1, done: 1'b0}, "right after start");
        if (busy_checks) begin
            // ignored, job already running
            reg_write(REG_CTRL, 32'd1);
        end
        st.done = 1'b0;
        while (!st.done) begin
            read_status(st);
        end
        check_status(st, '{busy: 1'b0, done: 1'b1}, "job end");
        if (busy_checks) begin
            repeat (40) @(posedge clk);
            read_status(st);
            check_status(st, '{busy: 1'b0, done: 1'b1}, "idle after ignored start");
        end
        check_word(word_t'(write_count), 32'd16, "C write count");
        // reference C in integer arithmetic
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                cv = 0;
                for (int k = 0; k < 4; k++) begin
                    cv = cv + am[i][k] * bm[k][j];
                end
                if (!mem.exists(cur_c + 4*(4*i + j))) begin
                    $display("C word for row %0d column %0d was never written", i, j);
                    abort_run();
                end
                check_word(mem[cur_c + 4*(4*i + j)], word_t'(cv),
                           $sformatf("C(%0d,%0d)", i, j));
            end
        end
    endtask

    initial begin
        status_t st;
        void'($urandom(77936));
        rst_n     = 1'b0;
        apb_req   = '0;
        mem_ready = 1'b0;
        mem_rsp   = '0;
        cyc       = 0;
        cur_c     = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        read_status(st);
        check_status(st, '{busy: 1'b0, done: 1'b0}, "after reset");
        register_tests();
        for (int n = 0; n < NUM_JOBS; n++) begin
            run_job(n == 0);
        end
        $display("Everything OK");
        $finish;
    end

    // watchdog sized from the job count
    initial begin
        repeat (8 + NUM_JOBS * JOB_CYCLES + REG_CYCLES) @(posedge clk);
        $display("watchdog ran out before the tests finished");
        abort_run();
    end

endmodule

/* testbench/mm_accel_sva.sv */
// DMA engine protocol assertions
// request stability, mm_start pulse width, write-back window
`timescale 1ns/10ps

module mm_accel_sva (
    input logic             clk,
    input logic             rst_n,
    input mm_pkg::mem_req_t mem_req_i,
    input logic             mem_ready_i,
    input logic             mm_start_i,
    input logic             mm_done_i,
    input logic             job_done_i
);

    // open from the engine's done until the job ends
    logic wb_open_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_open_q <= 1'b0;
        end else if (mm_done_i) begin
            wb_open_q <= 1'b1;
        end else if (job_done_i) begin
            wb_open_q <= 1'b0;
        end
    end

    // stalled request keeps address and data
    property req_holds_when_stalled;
        @(posedge clk) disable iff (!rst_n)
        (mem_req_i.valid && !mem_ready_i) |=> $stable(mem_req_i);
    endproperty

    property mm_start_single_cycle;
        @(posedge clk) disable iff (!rst_n)
        mm_start_i |=> !mm_start_i;
    endproperty

    // C write-back only after the multiply has finished
    property writes_in_write_back_window;
        @(posedge clk) disable iff (!rst_n)
        (mem_req_i.valid && mem_req_i.write) |-> wb_open_q;
    endproperty

    assert property (req_holds_when_stalled)
        else $error("memory request changed while stalled");
    assert property (mm_start_single_cycle)
        else $error("mm_start held longer than one cycle");
    assert property (writes_in_write_back_window)
        else $error("write request outside the write-back window");

endmodule

bind mm_dma_engine mm_accel_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_req_i   (mem_req_o),
    .mem_ready_i (mem_req_ready_i),
    .mm_start_i  (mm_start_o),
    .mm_done_i   (mm_done_i),
    .job_done_i  (job_done_o)
);

/* design/mm_accel_top.sv */
// matrix-multiply accelerator top
// APB registers, DMA, A/B row buffers and MAC engine
`timescale 1ns/10ps

module mm_accel_top (
    input  logic             clk,
    input  logic             rst_n,
    input  mm_pkg::apb_req_t apb_i,
    output mm_pkg::apb_rsp_t apb_o,
    output mm_pkg::mem_req_t mem_req_o,
    input  logic             mem_req_ready_i,
    input  mm_pkg::mem_rsp_t mem_rsp_i
);
    import mm_pkg::*;

    dma_cfg_t          cfg;
    logic              start;
    logic              job_done;
    buf_wr_t           buf_a_wr;
    buf_wr_t           buf_b_wr;
    logic              mm_start;
    logic              mm_done;
    logic [BUF_AW-1:0] a_raddr;
    logic [BUF_AW-1:0] b_raddr;
    row_t              a_row;
    row_t              b_row;
    accum_t            accum;

    // status only leaves through the APB read path
    mm_apb_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_i      (apb_i),
        .apb_o      (apb_o),
        .job_done_i (job_done),
        .cfg_o      (cfg),
        .start_o    (start),
        .status_o   ()
    );

    mm_dma_engine u_dma (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_i           (cfg),
        .start_i         (start),
        .job_done_o      (job_done),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .buf_a_wr_o      (buf_a_wr),
        .buf_b_wr_o      (buf_b_wr),
        .mm_start_o      (mm_start),
        .mm_done_i       (mm_done),
        .accum_i         (accum)
    );

    mm_row_buffer buf_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (buf_a_wr),
        .raddr_i (a_raddr),
        .rdata_o (a_row)
    );

    mm_row_buffer buf_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (buf_b_wr),
        .raddr_i (b_raddr),
        .rdata_o (b_row)
    );

    mm_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .done_o    (mm_done),
        .a_raddr_o (a_raddr),
        .b_raddr_o (b_raddr),
        .a_row_i   (a_row),
        .b_row_i   (b_row),
        .accum_o   (accum)
    );

endmodule

/* design/mm_engine.sv */
// sequential multiply-accumulate engine
// steps row i and index k, adds A[i][k] * B row k into C row i
`timescale 1ns/10ps

module mm_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    output logic                      done_o,
    output logic [mm_pkg::BUF_AW-1:0] a_raddr_o,
    output logic [mm_pkg::BUF_AW-1:0] b_raddr_o,
    input  mm_pkg::row_t              a_row_i,
    input  mm_pkg::row_t              b_row_i,
    output mm_pkg::accum_t            accum_o
);
    import mm_pkg::*;

    mm_state_e         state_q;
    // step = {i, k}
    logic [3:0]        step_q;
    // read pipeline stage, rows land one cycle after the address
    logic              valid_q;
    logic [BUF_AW-1:0] row_q;
    logic [BUF_AW-1:0] idx_q;
    logic              done_q;
    accum_t            accum_q;
    elem_t             a_elem;
    acc_t [SA_WIDTH-1:0] prod;

    assign a_raddr_o = step_q[3:2];
    assign b_raddr_o = step_q[1:0];

    // A[i][k] times each element of B row k, sign-extended
    always_comb begin
        a_elem = a_row_i[idx_q];
        for (int j = 0; j < SA_WIDTH; j++) begin
            prod[j] = a_elem * b_row_i[j];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            step_q  <= '0;
            valid_q <= 1'b0;
            row_q   <= '0;
            idx_q   <= '0;
            done_q  <= 1'b0;
            accum_q <= '0;
        end else begin
            valid_q <= (state_q == MM_RUN);
            row_q   <= step_q[3:2];
            idx_q   <= step_q[1:0];
            // raised alongside the final accumulate, 17 cycles after start
            done_q  <= (state_q == MM_RUN) && (step_q == 4'd15);
            if (start_i) begin
                state_q <= MM_RUN;
                step_q  <= '0;
                accum_q <= '0;
            end else begin
                if (state_q == MM_RUN) begin
                    step_q <= step_q + 4'd1;
                    if (step_q == 4'd15) begin
                        state_q <= MM_IDLE;
                    end
                end
                if (valid_q) begin
                    for (int j = 0; j < SA_WIDTH; j++) begin
                        accum_q[row_q][j] <= accum_q[row_q][j] + prod[j];
                    end
                end
            end
        end
    end

    assign done_o  = done_q;
    // holds until the next start
    assign accum_o = accum_q;

endmodule

/* design/mm_dma_engine.sv */
// DMA job sequencer
// reads A and B rows into the buffers, starts the multiply,
// then writes the sixteen C words back to memory
`timescale 1ns/10ps

module mm_dma_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  mm_pkg::dma_cfg_t cfg_i,
    input  logic             start_i,
    output logic             job_done_o,
    output mm_pkg::mem_req_t mem_req_o,
    input  logic             mem_req_ready_i,
    input  mm_pkg::mem_rsp_t mem_rsp_i,
    output mm_pkg::buf_wr_t  buf_a_wr_o,
    output mm_pkg::buf_wr_t  buf_b_wr_o,
    output logic             mm_start_o,
    input  logic             mm_done_i,
    input  mm_pkg::accum_t   accum_i
);
    import mm_pkg::*;

    dma_state_e state_q;
    dma_cfg_t   cfg_q;
    // issued requests, reads 0..8 then writes 0..15
    logic [3:0] issue_q;
    // returned read responses, 0..7
    logic [2:0] rsp_q;
    logic       accept;
    logic       rsp_in;
    acc_t       c_elem;

    // request is a function of state and issue count only,
    // so it holds steady while ready is low
    always_comb begin
        mem_req_o = '0;
        // row-major select of C(i,j)
        c_elem    = accum_i[issue_q[3:2]][issue_q[1:0]];
        case (state_q)
            READ: begin
                // A rows 0..3 then B rows 0..3
                mem_req_o.valid = !issue_q[3];
                mem_req_o.addr  = (issue_q[2] ? cfg_q.b_addr : cfg_q.a_addr)
                                  + {issue_q[1:0], 2'b00};
            end
            WRITE_C: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = cfg_q.c_addr + {issue_q, 2'b00};
                // sign-extend accumulator to a full word
                mem_req_o.wdata = {{(WORD_W-ACC_W){c_elem[ACC_W-1]}}, c_elem};
            end
            default: ;
        endcase
    end

    assign accept = mem_req_o.valid && mem_req_ready_i;
    assign rsp_in = (state_q == READ) && mem_rsp_i.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            cfg_q      <= '0;
            issue_q    <= '0;
            rsp_q      <= '0;
            mm_start_o <= 1'b0;
            job_done_o <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            job_done_o <= 1'b0;
            if (accept) begin
                issue_q <= issue_q + 4'd1;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        // snapshot bases, host may rewrite them mid-job
                        cfg_q   <= cfg_i;
                        issue_q <= '0;
                        rsp_q   <= '0;
                        state_q <= READ;
                    end
                end
                READ: begin
                    if (rsp_in) begin
                        rsp_q <= rsp_q + 3'd1;
                        // eighth response, kick the engine
                        if (rsp_q == 3'd7) begin
                            mm_start_o <= 1'b1;
                            state_q    <= WAIT_MM;
                        end
                    end
                end
                WAIT_MM: begin
                    if (mm_done_i) begin
                        issue_q <= '0;
                        state_q <= WRITE_C;
                    end
                end
                WRITE_C: begin
                    // last C word accepted ends the job
                    if (accept && issue_q == 4'd15) begin
                        job_done_o <= 1'b1;
                        state_q    <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // buffer fill, one cycle behind the response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_wr_o <= '0;
            buf_b_wr_o <= '0;
        end else begin
            // first four responses are A rows
            buf_a_wr_o.wren  <= rsp_in && !rsp_q[2];
            buf_a_wr_o.waddr <= rsp_q[1:0];
            buf_a_wr_o.wdata <= row_t'(mem_rsp_i.rdata);
            buf_b_wr_o.wren  <= rsp_in && rsp_q[2];
            buf_b_wr_o.waddr <= rsp_q[1:0];
            buf_b_wr_o.wdata <= row_t'(mem_rsp_i.rdata);
        end
    end

endmodule

/* design/mm_row_buffer.sv */
// four-row matrix buffer
// one write port, registered read port
`timescale 1ns/10ps

module mm_row_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mm_pkg::buf_wr_t           wr_i,
    input  logic [mm_pkg::BUF_AW-1:0] raddr_i,
    output mm_pkg::row_t              rdata_o
);
    import mm_pkg::*;

    row_t mem_q [SA_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < SA_WIDTH; r++) begin
                mem_q[r] <= '0;
            end
            rdata_o <= '0;
        end else begin
            if (wr_i.wren) begin
                mem_q[wr_i.waddr] <= wr_i.wdata;
            end
            // data one cycle after the address
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

/* design/mm_apb_regs.sv */
// APB configuration registers for the accelerator
// base addresses, start pulse and busy/done status
`timescale 1ns/10ps

module mm_apb_regs (
    input  logic             clk,
    input  logic             rst_n,
    input  mm_pkg::apb_req_t apb_i,
    output mm_pkg::apb_rsp_t apb_o,
    input  logic             job_done_i,
    output mm_pkg::dma_cfg_t cfg_o,
    output logic             start_o,
    output mm_pkg::status_t  status_o
);
    import mm_pkg::*;

    reg_addr_e reg_sel;
    logic      access;
    logic      mapped;
    logic      start_req;
    word_t     rdata;
    dma_cfg_t  cfg_q;
    status_t   status_q;
    logic      start_q;

    // access phase of a zero-wait transfer
    assign access  = apb_i.psel && apb_i.penable;
    assign reg_sel = reg_addr_e'(apb_i.paddr);

    // ctrl bit 0, dropped while a job runs
    assign start_req = access && apb_i.pwrite && (reg_sel == REG_CTRL)
                       && apb_i.pwdata[0] && !status_q.busy;

    // read mux and offset decode
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (reg_sel)
            REG_A_ADDR: rdata = cfg_q.a_addr;
            REG_B_ADDR: rdata = cfg_q.b_addr;
            REG_C_ADDR: rdata = cfg_q.c_addr;
            REG_CTRL:   rdata = WORD_W'({status_q.done, status_q.busy});
            default:    mapped = 1'b0;
        endcase
    end

    assign apb_o.prdata  = (access && mapped) ? rdata : '0;
    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = access && !mapped;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q    <= '0;
            status_q <= '0;
            start_q  <= 1'b0;
        end else begin
            start_q <= start_req;
            if (access && apb_i.pwrite) begin
                case (reg_sel)
                    REG_A_ADDR: cfg_q.a_addr <= apb_i.pwdata;
                    REG_B_ADDR: cfg_q.b_addr <= apb_i.pwdata;
                    REG_C_ADDR: cfg_q.c_addr <= apb_i.pwdata;
                    default: ;
                endcase
            end
            // start wins, job_done cannot coincide with it
            if (start_req) begin
                status_q.busy <= 1'b1;
                status_q.done <= 1'b0;
            end else if (job_done_i) begin
                status_q.busy <= 1'b0;
                status_q.done <= 1'b1;
            end
        end
    end

    assign cfg_o    = cfg_q;
    assign start_o  = start_q;
    assign status_o = status_q;

endmodule

/* design/mm_pkg.sv */
// matrix-multiply accelerator shared definitions
// sizes, bus structs, register map and FSM encodings
package mm_pkg;

    // fixed 4x4 problem, one row per memory word
    localparam int SA_WIDTH = 4;
    localparam int ELEM_W   = 8;
    // four 16-bit products summed, no overflow
    localparam int ACC_W    = 18;
    localparam int WORD_W   = 32;
    localparam int BUF_AW   = 2;

    typedef logic [WORD_W-1:0]        word_t;
    typedef logic signed [ELEM_W-1:0] elem_t;
    // element 0 sits in the low byte
    typedef elem_t [SA_WIDTH-1:0]     row_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    // indexed [row][col]
    typedef acc_t [SA_WIDTH-1:0][SA_WIDTH-1:0] accum_t;

    // memory request, write accepted means write complete
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // read response, in request order
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        word_t      pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic              wren;
        logic [BUF_AW-1:0] waddr;
        row_t              wdata;
    } buf_wr_t;

    typedef struct packed {
        word_t a_addr;
        word_t b_addr;
        word_t c_addr;
    } dma_cfg_t;

    typedef struct packed {
        logic busy;
        logic done;
    } status_t;

    typedef enum logic [7:0] {
        REG_A_ADDR = 8'h00,
        REG_B_ADDR = 8'h04,
        REG_C_ADDR = 8'h08,
        REG_CTRL   = 8'h0C
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT_MM,
        WRITE_C
    } dma_state_e;

    typedef enum logic {
        MM_IDLE,
        MM_RUN
    } mm_state_e;

endpackage
